// ==== bench/tb_daq.sv ====
`include "daq_settings.svh"

module tb_daq;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CH      = `DAQ_NUM_CH;
    localparam int DEPTH       = `DAQ_DEPTH;
    localparam int STAT_W      = NUM_CH * 9;
    localparam int NUM_TESTS   = 7;
    localparam int BURST_CYC   = 2 * 70 + 8;           // longest burst is 70 bytes.
    localparam int FRAME_CYC   = 270;
    localparam int CYCLE_LIMIT = 2 * (8 + NUM_TESTS * (BURST_CYC + FRAME_CYC + 8));

    logic                            clk;
    logic                            rst;
    daq_pkg::nibble_t  [NUM_CH-1:0]  pin_rxd;
    logic              [NUM_CH-1:0]  pin_read;
    logic                            fs;
    daq_pkg::btype_t                 btype;
    daq_pkg::ch_stat_t [NUM_CH-1:0]  dev_stat;
    logic                            ram_data_txen;
    daq_pkg::tx_addr_t               ram_data_txa;
    daq_pkg::byte_t                  ram_data_txd;
    logic                            fd;

    logic [31:0]       lcg_state = 32'd7005;
    string             test_name = "reset_idle";
    daq_pkg::byte_t    sent [NUM_CH][80];              // bytes pushed into each lane.
    int                n_bytes [NUM_CH];
    bit                tail_nib [NUM_CH];              // burst ends on a lone low nibble.
    daq_pkg::byte_t    exp_frame [512];
    int                exp_len = 0;
    logic [STAT_W-1:0] exp_stat;
    logic              chk_stat;
    int                wr_count = 0;
    int                cycles = 0;

    daq_top DUT (
        .clk(clk),
        .rst(rst),
        .pin_rxd(pin_rxd),
        .pin_read(pin_read),
        .fs(fs),
        .btype(btype),
        .dev_stat(dev_stat),
        .ram_data_txen(ram_data_txen),
        .ram_data_txa(ram_data_txa),
        .ram_data_txd(ram_data_txd),
        .fd(fd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic stop_with_fail(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error.");
    endtask

    task automatic report_mismatch(input string check, input logic [63:0] expected,
                                   input logic [63:0] actual);
        stop_with_fail($sformatf("[FAIL] %s %s expected %0h actual %0h",
                                 test_name, check, expected, actual));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_fail("timeout: the run went past its cycle budget without finishing.");
        end
    end

    // frame writes seen since the last fs.
    always @(posedge clk) begin
        if (rst || fs) begin
            wr_count <= 0;
        end else if (ram_data_txen) begin
            wr_count <= wr_count + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> (!ram_data_txen && !fd))
        else report_mismatch("reset_idle", 64'd0, 64'({$sampled(ram_data_txen), $sampled(fd)}));

    a_frame_range: assert property (@(posedge clk) disable iff (rst)
        ram_data_txen |-> (int'(ram_data_txa) < exp_len))
        else report_mismatch("frame_range", 64'(exp_len - 1), 64'($sampled(ram_data_txa)));

    a_frame_byte: assert property (@(posedge clk) disable iff (rst)
        ram_data_txen |-> (ram_data_txd == exp_frame[ram_data_txa]))
        else report_mismatch("frame_byte", 64'(exp_frame[$sampled(ram_data_txa)]),
                             64'($sampled(ram_data_txd)));

    a_hdr_timing: assert property (@(posedge clk) disable iff (rst)
        fs |=> (ram_data_txen && ram_data_txa == '0))
        else report_mismatch("hdr_timing", 64'd1, 64'($sampled(ram_data_txen)));

    a_fd_timing: assert property (@(posedge clk) disable iff (rst)
        (ram_data_txen && int'(ram_data_txa) == exp_len - 1) |=> fd)
        else report_mismatch("fd_timing", 64'd1, 64'($sampled(fd)));

    a_write_count: assert property (@(posedge clk) disable iff (rst)
        fd |-> (wr_count == exp_len))
        else report_mismatch("write_count", 64'(exp_len), 64'($sampled(wr_count)));

    a_clear: assert property (@(posedge clk) disable iff (rst) fd |=> (dev_stat == '0))
        else report_mismatch("clear", 64'd0, 64'($sampled(dev_stat)));

    a_status: assert property (@(posedge clk) disable iff (rst)
        chk_stat |-> (dev_stat == exp_stat))
        else report_mismatch("status", 64'(exp_stat), 64'($sampled(dev_stat)));

    task automatic load_counts(input int c0, input int c1, input int c2, input int c3);
        n_bytes[0] = c0;
        n_bytes[1] = c1;
        n_bytes[2] = c2;
        n_bytes[3] = c3;
        for (int i = 0; i < NUM_CH; i++) begin
            tail_nib[i] = 1'b0;
        end
    endtask

    // all lanes stream at once and each stops after its own length.
    task automatic send_bursts();
        int max_len;
        int nib_len;
        logic [31:0] rnd;
        max_len = 0;
        for (int i = 0; i < NUM_CH; i++) begin
            for (int b = 0; b < n_bytes[i]; b++) begin
                rnd = lcg_next();
                sent[i][b] = rnd[23:16];
            end
            nib_len = 2 * n_bytes[i] + int'(tail_nib[i]);
            if (nib_len > max_len) begin
                max_len = nib_len;
            end
        end
        for (int k = 0; k < max_len; k++) begin
            @(posedge clk);
            #1;
            for (int i = 0; i < NUM_CH; i++) begin
                if (k < 2 * n_bytes[i]) begin
                    pin_read[i] = 1'b1;
                    pin_rxd[i]  = k[0] ? sent[i][k/2][7:4] : sent[i][k/2][3:0];
                end else if (k < 2 * n_bytes[i] + int'(tail_nib[i])) begin
                    rnd         = lcg_next();
                    pin_read[i] = 1'b1;
                    pin_rxd[i]  = rnd[19:16];      // half byte that gets dropped.
                end else begin
                    pin_read[i] = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1;
        pin_read = '0;
    endtask

    task automatic check_status(input string name);
        int  cnt;
        bit  ovf;
        bit  odd;
        test_name = name;
        for (int i = 0; i < NUM_CH; i++) begin
            cnt = (n_bytes[i] > DEPTH) ? DEPTH : n_bytes[i];
            ovf = (n_bytes[i] > DEPTH) || (n_bytes[i] == DEPTH && tail_nib[i]);
            odd = tail_nib[i] && (n_bytes[i] < DEPTH);
            exp_stat[i*9 +: 9] = {ovf, odd, 7'(cnt)};
        end
        @(posedge clk);
        #1;
        chk_stat = 1'b1;
        @(posedge clk);
        #1;
        chk_stat = 1'b0;
    endtask

    task automatic run_frame(input string name);
        int              len;
        logic [31:0]     rnd;
        daq_pkg::btype_t bt;
        daq_pkg::byte_t  sum;
        test_name = name;
        rnd = lcg_next();
        bt  = rnd[27:24];
        len = DEPTH;
        for (int i = 0; i < NUM_CH; i++) begin
            if (n_bytes[i] < len) begin
                len = n_bytes[i];
            end
        end
        exp_frame[0] = {`DAQ_HDR_TAG, bt};
        exp_frame[1] = 8'(len);
        for (int r = 0; r < len; r++) begin
            for (int i = 0; i < NUM_CH; i++) begin
                exp_frame[2 + r * NUM_CH + i] = sent[i][r];
            end
        end
        exp_len = 3 + len * NUM_CH;
        sum = '0;
        for (int a = 0; a < exp_len - 1; a++) begin
            sum = sum ^ exp_frame[a];
        end
        exp_frame[exp_len - 1] = sum;
        @(posedge clk);
        #1;
        fs    = 1'b1;
        btype = bt;
        @(posedge clk);
        #1;
        fs    = 1'b0;
        btype = ~bt;                                   // header must keep the type seen at fs.
        do begin
            @(posedge clk);
            #1;
        end while (fd !== 1'b1);
    endtask

    task automatic run_case(input string name);
        send_bursts();
        check_status(name);
        run_frame(name);
        load_counts(0, 0, 0, 0);
        check_status({name, "_clear"});                // receivers rearmed by fd.
    endtask

    initial begin
        logic [31:0] rnd;
        rst      = 1'b1;
        pin_rxd  = '0;
        pin_read = '0;
        fs       = 1'b0;
        btype    = '0;
        chk_stat = 1'b0;
        load_counts(0, 0, 0, 0);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_status("reset_idle");

        for (int t = 0; t < 3; t++) begin
            for (int i = 0; i < NUM_CH; i++) begin
                rnd        = lcg_next();
                n_bytes[i] = 1 + int'(rnd[23:16]) % 48;
                tail_nib[i] = 1'b0;
            end
            run_case("byte_assembly");
        end

        load_counts(20, 9, 33, 15);
        run_case("short_lane");
        load_counts(5, 0, 8, 3);
        run_case("empty_lane");                        // header, length and checksum only.

        load_counts(6, 6, 3, 6);
        tail_nib[2] = 1'b1;
        run_case("odd_nibble");

        load_counts(64, 70, 64, 64);
        run_case("overflow");

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== design/daq_pkg.sv ====
`include "daq_settings.svh"

package daq_pkg;

    typedef logic [3:0] nibble_t;                   // serial word from a receiver pin.
    typedef logic [7:0] byte_t;
    typedef logic [3:0] btype_t;                    // frame type for the low nibble of the header.
    typedef logic [`DAQ_ADDR_W-1:0] row_addr_t;
    typedef logic [`DAQ_CNT_W-1:0] cnt_t;

    // {overflow, odd nibble, count}.
    typedef logic [8:0] ch_stat_t;

    typedef logic [8:0] tx_addr_t;                  // largest frame is 259 bytes.

    typedef enum logic [1:0] {
        RX_LOW,
        RX_HIGH,
        RX_FULL
    } rx_state_t;

    typedef enum logic [2:0] {
        MK_IDLE,
        MK_HDR,
        MK_LEN,
        MK_ROWS,
        MK_SUM
    } mk_state_t;

endpackage

// ==== design/daq_settings.svh ====
`ifndef DAQ_SETTINGS_SVH
`define DAQ_SETTINGS_SVH

// number of receiver lanes.
`define DAQ_NUM_CH 4

// rows held per lane in the row buffer.
`define DAQ_DEPTH 64

// row address width to cover DAQ_DEPTH.
`define DAQ_ADDR_W 6

// byte count width is one bit wider than the address so a full lane reads 64.
`define DAQ_CNT_W 7

// upper nibble of every frame header.
`define DAQ_HDR_TAG 4'hA

`endif

// ==== design/daq_top.sv ====
`include "daq_settings.svh"

module daq_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  daq_pkg::nibble_t       [`DAQ_NUM_CH-1:0]   pin_rxd,
    input  logic                   [`DAQ_NUM_CH-1:0]   pin_read,
    input  logic                                       fs,
    input  daq_pkg::btype_t                            btype,
    output wire daq_pkg::ch_stat_t [`DAQ_NUM_CH-1:0]   dev_stat,
    output logic                                       ram_data_txen,
    output daq_pkg::tx_addr_t                          ram_data_txa,
    output daq_pkg::byte_t                             ram_data_txd,
    output logic                                       fd
);

    wire logic               [`DAQ_NUM_CH-1:0] ram_txen;
    wire daq_pkg::row_addr_t [`DAQ_NUM_CH-1:0] ram_txa;
    wire daq_pkg::byte_t     [`DAQ_NUM_CH-1:0] ram_txd;
    wire daq_pkg::byte_t     [`DAQ_NUM_CH-1:0] ram_rxd;
    wire daq_pkg::row_addr_t                   ram_rxa;

    for (genvar i = 0; i < `DAQ_NUM_CH; i++) begin : usb_inst
        usb_rx
        usb_dut (
            .clk(clk),
            .rst(rst),
            .clear(fd),                          // a finished frame rearms capture.

            .pin_rxd(pin_rxd[i]),
            .pin_read(pin_read[i]),

            .ram_txen(ram_txen[i]),
            .ram_txa(ram_txa[i]),
            .ram_txd(ram_txd[i]),

            .cache_stat(dev_stat[i])
        );
    end

    ram_usb
    ram_usb_dut (
        .clk(clk),
        .txen(ram_txen),
        .txa(ram_txa),
        .txd(ram_txd),
        .rxa(ram_rxa),
        .rxd(ram_rxd)
    );

    data_make
    data_make_dut (
        .clk(clk),
        .rst(rst),

        .fs(fs),
        .btype(btype),
        .usb_stat(dev_stat),

        .ram_rxa(ram_rxa),
        .ram_rxd(ram_rxd),

        .ram_data_txen(ram_data_txen),
        .ram_data_txa(ram_data_txa),
        .ram_data_txd(ram_data_txd),

        .fd(fd)
    );

endmodule

// ==== design/data_make.sv ====
`include "daq_settings.svh"

module data_make (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  fs,
    input  daq_pkg::btype_t                       btype,
    input  daq_pkg::ch_stat_t [`DAQ_NUM_CH-1:0]   usb_stat,
    input  daq_pkg::byte_t    [`DAQ_NUM_CH-1:0]   ram_rxd,
    output daq_pkg::row_addr_t                    ram_rxa,
    output logic                                  ram_data_txen,
    output daq_pkg::tx_addr_t                     ram_data_txa,
    output daq_pkg::byte_t                        ram_data_txd,
    output logic                                  fd
);

    localparam int NUM_CH = `DAQ_NUM_CH;
    localparam int LANE_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(NUM_CH - 1);

    daq_pkg::mk_state_t state;
    daq_pkg::btype_t    btype_q;
    daq_pkg::cnt_t      len_q;
    daq_pkg::cnt_t      min_cnt;
    daq_pkg::row_addr_t row;
    logic [LANE_W-1:0]  lane;
    daq_pkg::tx_addr_t  txa_q;
    daq_pkg::byte_t     sum;
    logic               last_row;

    // frame length is the shortest lane.
    always_comb begin
        min_cnt = usb_stat[0][`DAQ_CNT_W-1:0];
        for (int i = 1; i < NUM_CH; i++) begin
            if (usb_stat[i][`DAQ_CNT_W-1:0] < min_cnt) begin
                min_cnt = usb_stat[i][`DAQ_CNT_W-1:0];
            end
        end
    end

    assign last_row = (daq_pkg::cnt_t'(row) + 1'b1 == len_q);

    // next row is requested while the last lane of this one goes out.
    assign ram_rxa = (state == daq_pkg::MK_ROWS && lane == LAST_LANE) ? row + 1'b1 : row;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= daq_pkg::MK_IDLE;
            fd    <= 1'b0;
            row   <= '0;
            lane  <= '0;
            txa_q <= '0;
            sum   <= '0;
        end else begin
            fd <= 1'b0;
            if (ram_data_txen) begin
                txa_q <= txa_q + 1'b1;
                sum   <= sum ^ ram_data_txd;     // running checksum.
            end
            case (state)
                daq_pkg::MK_IDLE: begin
                    if (fs) begin
                        state <= daq_pkg::MK_HDR;
                        txa_q <= '0;
                        sum   <= '0;
                        row   <= '0;
                        lane  <= '0;
                    end
                end
                daq_pkg::MK_HDR: begin
                    state <= daq_pkg::MK_LEN;
                end
                daq_pkg::MK_LEN: begin
                    if (len_q == '0) begin
                        state <= daq_pkg::MK_SUM;
                    end else begin
                        state <= daq_pkg::MK_ROWS;
                    end
                end
                daq_pkg::MK_ROWS: begin
                    if (lane == LAST_LANE) begin
                        lane <= '0;
                        if (last_row) begin
                            state <= daq_pkg::MK_SUM;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        lane <= lane + 1'b1;
                    end
                end
                daq_pkg::MK_SUM: begin
                    state <= daq_pkg::MK_IDLE;
                    fd    <= 1'b1;
                end
                default: begin
                    state <= daq_pkg::MK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == daq_pkg::MK_IDLE && fs) begin
            btype_q <= btype;
            len_q   <= min_cnt;
        end
    end

    assign ram_data_txen = (state != daq_pkg::MK_IDLE);
    assign ram_data_txa  = txa_q;

    always_comb begin
        case (state)
            daq_pkg::MK_HDR:  ram_data_txd = {`DAQ_HDR_TAG, btype_q};
            daq_pkg::MK_LEN:  ram_data_txd = daq_pkg::byte_t'(len_q);
            daq_pkg::MK_ROWS: ram_data_txd = ram_rxd[lane];
            daq_pkg::MK_SUM:  ram_data_txd = sum;
            default:          ram_data_txd = '0;
        endcase
    end

    a_fs_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        fs |-> (state == daq_pkg::MK_IDLE)
    ) else $error("fs arrived while a frame was in progress.");

    a_fd_single: assert property (
        @(posedge clk) disable iff (rst)
        fd |=> !fd
    ) else $error("fd held longer than one cycle.");

    // writes inside a frame land on consecutive addresses.
    a_txa_step: assert property (
        @(posedge clk) disable iff (rst)
        (ram_data_txen && $past(ram_data_txen)) |-> (ram_data_txa == $past(ram_data_txa) + 1'b1)
    ) else $error("frame write address skipped.");

endmodule

// ==== design/ram_usb.sv ====
`include "daq_settings.svh"

module ram_usb (
    input  logic                                   clk,
    input  logic               [`DAQ_NUM_CH-1:0]   txen,
    input  daq_pkg::row_addr_t [`DAQ_NUM_CH-1:0]   txa,
    input  daq_pkg::byte_t     [`DAQ_NUM_CH-1:0]   txd,
    input  daq_pkg::row_addr_t                     rxa,
    output daq_pkg::byte_t     [`DAQ_NUM_CH-1:0]   rxd
);

    // one memory per lane and every lane reads the same row.
    for (genvar i = 0; i < `DAQ_NUM_CH; i++) begin : g_lane

        daq_pkg::byte_t mem [`DAQ_DEPTH];
        daq_pkg::byte_t rd_q;

        always_ff @(posedge clk) begin
            if (txen[i]) begin
                mem[txa[i]] <= txd[i];           // lane owned by receiver i.
            end
            rd_q <= mem[rxa];                    // one cycle read latency.
        end

        assign rxd[i] = rd_q;

    end

endmodule

// ==== design/usb_rx.sv ====
`include "daq_settings.svh"

module usb_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  daq_pkg::nibble_t   pin_rxd,
    input  logic               pin_read,
    output logic               ram_txen,
    output daq_pkg::row_addr_t ram_txa,
    output daq_pkg::byte_t     ram_txd,
    output daq_pkg::ch_stat_t  cache_stat
);

    localparam daq_pkg::cnt_t DEPTH = daq_pkg::cnt_t'(`DAQ_DEPTH);

    daq_pkg::rx_state_t state;
    daq_pkg::cnt_t      count;
    daq_pkg::nibble_t   low_q;
    logic               odd_flag;
    logic               ovf_flag;
    logic               take_low;
    logic               take_high;

    assign take_low  = pin_read && (state == daq_pkg::RX_LOW);
    assign take_high = pin_read && (state == daq_pkg::RX_HIGH);

    // nibble pairing, byte count and error flags.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            state    <= daq_pkg::RX_LOW;
            count    <= '0;
            odd_flag <= 1'b0;
            ovf_flag <= 1'b0;
            ram_txen <= 1'b0;
        end else begin
            ram_txen <= 1'b0;
            case (state)
                daq_pkg::RX_LOW: begin
                    if (pin_read) begin
                        state <= daq_pkg::RX_HIGH;
                    end
                end
                daq_pkg::RX_HIGH: begin
                    if (pin_read) begin
                        ram_txen <= 1'b1;
                        count    <= count + 1'b1;
                        if (count == DEPTH - 1'b1) begin
                            state <= daq_pkg::RX_FULL;     // last row taken.
                        end else begin
                            state <= daq_pkg::RX_LOW;
                        end
                    end else begin
                        odd_flag <= 1'b1;                  // burst ended mid byte.
                        state    <= daq_pkg::RX_LOW;
                    end
                end
                daq_pkg::RX_FULL: begin
                    if (pin_read) begin
                        ovf_flag <= 1'b1;                  // data beyond depth is lost.
                    end
                end
                default: begin
                    state <= daq_pkg::RX_LOW;
                end
            endcase
        end
    end

    // low half is held until its partner nibble shows up.
    always_ff @(posedge clk) begin
        if (take_low) begin
            low_q <= pin_rxd;
        end
        if (take_high) begin
            ram_txd <= {pin_rxd, low_q};
            ram_txa <= daq_pkg::row_addr_t'(count);
        end
    end

    assign cache_stat = {ovf_flag, odd_flag, count};

    // a byte write must come from a row below depth.
    a_no_write_at_depth: assert property (
        @(posedge clk) disable iff (rst)
        ram_txen |-> ($past(count) < DEPTH)
    ) else $error("usb_rx wrote with count at depth.");

endmodule

// ==== filelist.f ====
+incdir+design
design/daq_pkg.sv
design/usb_rx.sv
design/ram_usb.sv
design/data_make.sv
design/daq_top.sv
bench/tb_daq.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it once.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_daq -f filelist.f -o sim_tb_daq \
    && ./obj_dir/sim_tb_daq | tee /dev/stderr | grep "RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
